// ==== hdl/decode_macros.svh ====
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// datapath and pc width
`define XLEN 64

// instruction word width
`define ILEN 32

`define REG_IDX_W 5

// funct7 for add/sub and srl/sra selection
`define F7_NORMAL  7'b0000000
`define F7_SUB_SRA 7'b0100000

// rv64 immediate shifts keep only six funct7 bits
`define SHAMT6_NORMAL 6'b000000
`define SHAMT6_SRA    6'b010000

`endif

// ==== hdl/decode_pkg.sv ====
`default_nettype none

`include "decode_macros.svh"

package decode_pkg;

    typedef enum logic [6:0] {
        OP_LUI     = 7'b0110111,
        OP_AUIPC   = 7'b0010111,
        OP_JAL     = 7'b1101111,
        OP_JALR    = 7'b1100111,
        OP_BRANCH  = 7'b1100011,
        OP_LOAD    = 7'b0000011,
        OP_STORE   = 7'b0100011,
        OP_ALU_I   = 7'b0010011,
        OP_ALU     = 7'b0110011,
        OP_ALU_I_W = 7'b0011011,
        OP_ALU_W   = 7'b0111011
    } opcode_e;

    // the same 32 bits seen through every base format
    typedef union packed {
        struct packed {
            logic [6:0]            func7;
            logic [`REG_IDX_W-1:0] rs2;
            logic [`REG_IDX_W-1:0] rs1;
            logic [2:0]            func3;
            logic [`REG_IDX_W-1:0] rd;
            logic [6:0]            opcode;
        } rtype;
        struct packed {
            logic [11:0]           imm;
            logic [`REG_IDX_W-1:0] rs1;
            logic [2:0]            func3;
            logic [`REG_IDX_W-1:0] rd;
            logic [6:0]            opcode;
        } itype;
        struct packed {
            logic [6:0]            imm11_5;
            logic [`REG_IDX_W-1:0] rs2;
            logic [`REG_IDX_W-1:0] rs1;
            logic [2:0]            func3;
            logic [4:0]            imm4_0;
            logic [6:0]            opcode;
        } stype;
        struct packed {
            logic                  imm12;
            logic [5:0]            imm10_5;
            logic [`REG_IDX_W-1:0] rs2;
            logic [`REG_IDX_W-1:0] rs1;
            logic [2:0]            func3;
            logic [3:0]            imm4_1;
            logic                  imm11;
            logic [6:0]            opcode;
        } btype;
        struct packed {
            logic [19:0]           imm31_12;
            logic [`REG_IDX_W-1:0] rd;
            logic [6:0]            opcode;
        } utype;
        struct packed {
            logic                  imm20;
            logic [9:0]            imm10_1;
            logic                  imm11;
            logic [7:0]            imm19_12;
            logic [`REG_IDX_W-1:0] rd;
            logic [6:0]            opcode;
        } jtype;
        struct packed {
            logic [6:0]            func7;
            logic [`REG_IDX_W-1:0] rs2;
            logic [`REG_IDX_W-1:0] rs1;
            logic [2:0]            func3;
            logic [`REG_IDX_W-1:0] rd;
            logic [6:0]            opcode;
        } common;
    } instr_word_u;

    // ADD first so an all-zero control word reads as add
    typedef enum logic [6:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        ADDW, SUBW, SLLW, SRLW, SRAW,
        JAL, JALR,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        LB, LH, LW, LD, LBU, LHU, LWU,
        SB, SH, SW, SD
    } instr_type_e;

    typedef enum logic [1:0] {
        UNIT_ALU,
        UNIT_BRANCH,
        UNIT_MEM
    } unit_e;

    typedef enum logic [1:0] {
        MEM_NOP,
        MEM_LOAD,
        MEM_STORE
    } mem_op_e;

    typedef enum logic [1:0] {
        SEL_FROM_ALU,
        SEL_FROM_BRANCH,
        SEL_FROM_MEM
    } wb_sel_e;

    // riscv mcause codes plus a none value
    typedef enum logic [3:0] {
        XCPT_INSTR_ADDR_MISALIGNED = 4'd0,
        XCPT_ILLEGAL_INSTR         = 4'd2,
        XCPT_NONE                  = 4'd15
    } xcpt_cause_e;

    typedef struct packed {
        logic              valid;
        xcpt_cause_e       cause;
        logic [`XLEN-1:0]  origin;
    } exception_t;

    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  pc;
        instr_word_u       inst;
        logic              bpred;
        exception_t        ex;
    } fetch_entry_t;

    typedef struct packed {
        instr_type_e       instr_type;
        unit_e             unit;
        mem_op_e           mem_op;
        wb_sel_e           regfile_w_sel;
        logic              regfile_we;
        logic              change_pc_ena;
        logic              use_imm;
        logic              use_pc;
        logic              op_32;
        logic              zero_rs1;
    } op_ctrl_t;

    typedef struct packed {
        logic                  valid;
        logic [`XLEN-1:0]      pc;
        logic                  bpred;
        logic [`REG_IDX_W-1:0] rs1;
        logic [`REG_IDX_W-1:0] rs2;
        logic [`REG_IDX_W-1:0] rd;
        logic [2:0]            funct3;
        logic [`XLEN-1:0]      imm;
        op_ctrl_t              ctrl;
        exception_t            ex;
    } decoded_instr_t;

    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  jump_addr;
    } jal_redirect_t;

endpackage

`default_nettype wire

// ==== hdl/imm_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decode_macros.svh"

module imm_gen
    import decode_pkg::*;
(
    input  instr_word_u        instr_i,
    output logic [`XLEN-1:0]   imm_o
);

    always_comb begin
        case (instr_i.common.opcode)
            OP_LOAD, OP_JALR, OP_ALU_I, OP_ALU_I_W: begin
                imm_o = {{(`XLEN-12){instr_i.itype.imm[11]}}, instr_i.itype.imm};
            end
            OP_STORE: begin
                imm_o = {{(`XLEN-12){instr_i.stype.imm11_5[6]}},
                         instr_i.stype.imm11_5, instr_i.stype.imm4_0};
            end
            // branch and jump offsets are in halfwords
            OP_BRANCH: begin
                imm_o = {{(`XLEN-13){instr_i.btype.imm12}}, instr_i.btype.imm12,
                         instr_i.btype.imm11, instr_i.btype.imm10_5,
                         instr_i.btype.imm4_1, 1'b0};
            end
            OP_LUI, OP_AUIPC: begin
                imm_o = {{(`XLEN-`ILEN){instr_i.utype.imm31_12[19]}},
                         instr_i.utype.imm31_12, 12'b0};
            end
            OP_JAL: begin
                imm_o = {{(`XLEN-21){instr_i.jtype.imm20}}, instr_i.jtype.imm20,
                         instr_i.jtype.imm19_12, instr_i.jtype.imm11,
                         instr_i.jtype.imm10_1, 1'b0};
            end
            default: begin
                imm_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/int_op_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decode_macros.svh"

module int_op_decode
    import decode_pkg::*;
(
    input  instr_word_u  instr_i,
    output logic         hit_o,
    output logic         illegal_o,
    output op_ctrl_t     ctrl_o
);

    logic [6:0] f7;
    logic [2:0] f3;

    assign f7 = instr_i.rtype.func7;
    assign f3 = instr_i.rtype.func3;

    always_comb begin
        hit_o     = 1'b0;
        illegal_o = 1'b0;
        // add on the alu without memory access
        ctrl_o    = '0;

        case (instr_i.common.opcode)
            OP_ALU: begin
                hit_o             = 1'b1;
                ctrl_o.regfile_we = 1'b1;
                // mul/div share this opcode and fall into default
                case ({f7, f3})
                    {`F7_NORMAL, 3'b000}:  ctrl_o.instr_type = ADD;
                    {`F7_SUB_SRA, 3'b000}: ctrl_o.instr_type = SUB;
                    {`F7_NORMAL, 3'b001}:  ctrl_o.instr_type = SLL;
                    {`F7_NORMAL, 3'b010}:  ctrl_o.instr_type = SLT;
                    {`F7_NORMAL, 3'b011}:  ctrl_o.instr_type = SLTU;
                    {`F7_NORMAL, 3'b100}:  ctrl_o.instr_type = XOR;
                    {`F7_NORMAL, 3'b101}:  ctrl_o.instr_type = SRL;
                    {`F7_SUB_SRA, 3'b101}: ctrl_o.instr_type = SRA;
                    {`F7_NORMAL, 3'b110}:  ctrl_o.instr_type = OR;
                    {`F7_NORMAL, 3'b111}:  ctrl_o.instr_type = AND;
                    default:               illegal_o = 1'b1;
                endcase
            end
            OP_ALU_I: begin
                hit_o             = 1'b1;
                ctrl_o.regfile_we = 1'b1;
                ctrl_o.use_imm    = 1'b1;
                case (f3)
                    3'b000: ctrl_o.instr_type = ADD;
                    3'b010: ctrl_o.instr_type = SLT;
                    3'b011: ctrl_o.instr_type = SLTU;
                    3'b100: ctrl_o.instr_type = XOR;
                    3'b110: ctrl_o.instr_type = OR;
                    3'b111: ctrl_o.instr_type = AND;
                    // shamt is six bits wide here
                    3'b001: begin
                        ctrl_o.instr_type = SLL;
                        illegal_o         = (f7[6:1] != `SHAMT6_NORMAL);
                    end
                    default: begin
                        case (f7[6:1])
                            `SHAMT6_NORMAL: ctrl_o.instr_type = SRL;
                            `SHAMT6_SRA:    ctrl_o.instr_type = SRA;
                            default:        illegal_o = 1'b1;
                        endcase
                    end
                endcase
            end
            OP_ALU_W: begin
                hit_o             = 1'b1;
                ctrl_o.regfile_we = 1'b1;
                ctrl_o.op_32      = 1'b1;
                case ({f7, f3})
                    {`F7_NORMAL, 3'b000}:  ctrl_o.instr_type = ADDW;
                    {`F7_SUB_SRA, 3'b000}: ctrl_o.instr_type = SUBW;
                    {`F7_NORMAL, 3'b001}:  ctrl_o.instr_type = SLLW;
                    {`F7_NORMAL, 3'b101}:  ctrl_o.instr_type = SRLW;
                    {`F7_SUB_SRA, 3'b101}: ctrl_o.instr_type = SRAW;
                    default:               illegal_o = 1'b1;
                endcase
            end
            OP_ALU_I_W: begin
                hit_o             = 1'b1;
                ctrl_o.regfile_we = 1'b1;
                ctrl_o.use_imm    = 1'b1;
                ctrl_o.op_32      = 1'b1;
                case (f3)
                    3'b000: ctrl_o.instr_type = ADDW;
                    3'b001: begin
                        ctrl_o.instr_type = SLLW;
                        illegal_o         = (f7 != `F7_NORMAL);
                    end
                    3'b101: begin
                        case (f7)
                            `F7_NORMAL:  ctrl_o.instr_type = SRLW;
                            `F7_SUB_SRA: ctrl_o.instr_type = SRAW;
                            default:     illegal_o = 1'b1;
                        endcase
                    end
                    default: illegal_o = 1'b1;
                endcase
            end
            default: begin
                hit_o = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/flow_mem_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decode_macros.svh"

module flow_mem_decode
    import decode_pkg::*;
(
    input  instr_word_u        instr_i,
    input  logic [`XLEN-1:0]   pc_i,
    input  logic [`XLEN-1:0]   imm_i,
    output logic               hit_o,
    output logic               illegal_o,
    output logic               misaligned_o,
    output op_ctrl_t           ctrl_o,
    output logic [`XLEN-1:0]   jump_addr_o
);

    logic [2:0] f3;

    assign f3          = instr_i.common.func3;
    assign jump_addr_o = pc_i + imm_i;

    always_comb begin
        hit_o        = 1'b0;
        illegal_o    = 1'b0;
        misaligned_o = 1'b0;
        ctrl_o       = '0;

        case (instr_i.common.opcode)
            // lui is x0 | imm on the alu
            OP_LUI: begin
                hit_o             = 1'b1;
                ctrl_o.regfile_we = 1'b1;
                ctrl_o.use_imm    = 1'b1;
                ctrl_o.zero_rs1   = 1'b1;
                ctrl_o.instr_type = OR;
            end
            OP_AUIPC: begin
                hit_o             = 1'b1;
                ctrl_o.regfile_we = 1'b1;
                ctrl_o.use_imm    = 1'b1;
                ctrl_o.use_pc     = 1'b1;
                ctrl_o.instr_type = ADD;
            end
            // redirect leaves from decode, so no pc change later
            OP_JAL: begin
                hit_o                = 1'b1;
                ctrl_o.regfile_we    = 1'b1;
                ctrl_o.use_imm       = 1'b1;
                ctrl_o.use_pc        = 1'b1;
                ctrl_o.instr_type    = JAL;
                ctrl_o.unit          = UNIT_BRANCH;
                ctrl_o.regfile_w_sel = SEL_FROM_BRANCH;
                misaligned_o         = |imm_i[1:0];
            end
            OP_JALR: begin
                hit_o                = 1'b1;
                ctrl_o.regfile_we    = 1'b1;
                ctrl_o.change_pc_ena = 1'b1;
                ctrl_o.use_imm       = 1'b1;
                ctrl_o.use_pc        = 1'b1;
                ctrl_o.instr_type    = JALR;
                ctrl_o.unit          = UNIT_BRANCH;
                ctrl_o.regfile_w_sel = SEL_FROM_BRANCH;
                illegal_o            = (f3 != 3'b000);
            end
            OP_BRANCH: begin
                hit_o                = 1'b1;
                ctrl_o.change_pc_ena = 1'b1;
                ctrl_o.use_imm       = 1'b1;
                ctrl_o.use_pc        = 1'b1;
                ctrl_o.unit          = UNIT_BRANCH;
                ctrl_o.regfile_w_sel = SEL_FROM_BRANCH;
                case (f3)
                    3'b000:  ctrl_o.instr_type = BEQ;
                    3'b001:  ctrl_o.instr_type = BNE;
                    3'b100:  ctrl_o.instr_type = BLT;
                    3'b101:  ctrl_o.instr_type = BGE;
                    3'b110:  ctrl_o.instr_type = BLTU;
                    3'b111:  ctrl_o.instr_type = BGEU;
                    default: illegal_o = 1'b1;
                endcase
            end
            OP_LOAD: begin
                hit_o                = 1'b1;
                ctrl_o.regfile_we    = 1'b1;
                ctrl_o.use_imm       = 1'b1;
                ctrl_o.unit          = UNIT_MEM;
                ctrl_o.mem_op        = MEM_LOAD;
                ctrl_o.regfile_w_sel = SEL_FROM_MEM;
                case (f3)
                    3'b000:  ctrl_o.instr_type = LB;
                    3'b001:  ctrl_o.instr_type = LH;
                    3'b010:  ctrl_o.instr_type = LW;
                    3'b011:  ctrl_o.instr_type = LD;
                    3'b100:  ctrl_o.instr_type = LBU;
                    3'b101:  ctrl_o.instr_type = LHU;
                    3'b110:  ctrl_o.instr_type = LWU;
                    default: illegal_o = 1'b1;
                endcase
            end
            OP_STORE: begin
                hit_o                = 1'b1;
                ctrl_o.use_imm       = 1'b1;
                ctrl_o.unit          = UNIT_MEM;
                ctrl_o.mem_op        = MEM_STORE;
                ctrl_o.regfile_w_sel = SEL_FROM_MEM;
                case (f3)
                    3'b000:  ctrl_o.instr_type = SB;
                    3'b001:  ctrl_o.instr_type = SH;
                    3'b010:  ctrl_o.instr_type = SW;
                    3'b011:  ctrl_o.instr_type = SD;
                    default: illegal_o = 1'b1;
                endcase
            end
            default: begin
                hit_o = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/id_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decode_macros.svh"

module id_stage
    import decode_pkg::*;
(
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  fetch_entry_t    fetch_i,
    output decoded_instr_t  decode_o,
    output jal_redirect_t   jal_o
);

    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] jump_addr;
    logic             int_hit;
    logic             int_illegal;
    logic             fm_hit;
    logic             fm_illegal;
    logic             fm_misaligned;
    op_ctrl_t         int_ctrl;
    op_ctrl_t         fm_ctrl;
    logic             do_decode;
    logic             illegal;
    logic             misaligned;
    decoded_instr_t   decode_d;
    jal_redirect_t    jal_d;

    imm_gen imm_gen_inst (
        .instr_i (fetch_i.inst),
        .imm_o   (imm)
    );

    int_op_decode int_op_decode_inst (
        .instr_i   (fetch_i.inst),
        .hit_o     (int_hit),
        .illegal_o (int_illegal),
        .ctrl_o    (int_ctrl)
    );

    flow_mem_decode flow_mem_decode_inst (
        .instr_i      (fetch_i.inst),
        .pc_i         (fetch_i.pc),
        .imm_i        (imm),
        .hit_o        (fm_hit),
        .illegal_o    (fm_illegal),
        .misaligned_o (fm_misaligned),
        .ctrl_o       (fm_ctrl),
        .jump_addr_o  (jump_addr)
    );

    // upstream exception wins over anything found here
    assign do_decode = fetch_i.valid & ~fetch_i.ex.valid;

    always_comb begin
        illegal           = 1'b0;
        misaligned        = 1'b0;
        decode_d.valid    = fetch_i.valid;
        decode_d.pc       = fetch_i.pc;
        decode_d.bpred    = fetch_i.bpred;
        decode_d.rs1      = fetch_i.inst.common.rs1;
        decode_d.rs2      = fetch_i.inst.common.rs2;
        decode_d.rd       = fetch_i.inst.common.rd;
        decode_d.funct3   = fetch_i.inst.common.func3;
        decode_d.imm      = imm;
        decode_d.ctrl     = '0;

        if (do_decode) begin
            if (int_hit) begin
                decode_d.ctrl = int_ctrl;
                illegal       = int_illegal;
            end else if (fm_hit) begin
                decode_d.ctrl = fm_ctrl;
                illegal       = fm_illegal;
                misaligned    = fm_misaligned;
            end else begin
                // dropped or unknown opcode
                illegal = 1'b1;
            end
            if (decode_d.ctrl.zero_rs1) begin
                decode_d.rs1 = '0;
            end
            // a faulting instruction must not write back or redirect
            if (illegal || misaligned) begin
                decode_d.ctrl.regfile_we    = 1'b0;
                decode_d.ctrl.change_pc_ena = 1'b0;
            end
        end

        if (fetch_i.ex.valid) begin
            decode_d.ex = fetch_i.ex;
        end else if (misaligned) begin
            decode_d.ex.valid  = 1'b1;
            decode_d.ex.cause  = XCPT_INSTR_ADDR_MISALIGNED;
            decode_d.ex.origin = jump_addr;
        end else if (illegal) begin
            decode_d.ex.valid  = 1'b1;
            decode_d.ex.cause  = XCPT_ILLEGAL_INSTR;
            decode_d.ex.origin = '0;
        end else begin
            decode_d.ex.valid  = 1'b0;
            decode_d.ex.cause  = XCPT_NONE;
            decode_d.ex.origin = '0;
        end
    end

    assign jal_d.valid     = do_decode & fm_hit & (fm_ctrl.instr_type == JAL) & ~fm_misaligned;
    assign jal_d.jump_addr = jump_addr;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            decode_o <= '0;
            jal_o    <= '0;
        end else begin
            decode_o <= decode_d;
            jal_o    <= jal_d;
        end
    end

endmodule

`default_nettype wire

// ==== tests/id_stage_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_stage_asserts
    import decode_pkg::*;
(
    input logic           clk_i,
    input logic           arst_n_i,
    input decoded_instr_t decode_i,
    input jal_redirect_t  jal_i
);

    int jal_align_fails = 0;
    int ex_we_fails     = 0;
    int reset_fails     = 0;

    // redirect only to a word aligned target
    jal_aligned: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        jal_i.valid |-> (jal_i.jump_addr[1:0] == 2'b00))
        else begin
            $error("jal redirect to a misaligned target");
            jal_align_fails = jal_align_fails + 1;
        end

    ex_no_write: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        decode_i.ex.valid |-> !decode_i.ctrl.regfile_we)
        else begin
            $error("faulting instruction writes the register file");
            ex_we_fails = ex_we_fails + 1;
        end

    reset_quiet: assert property (@(posedge clk_i)
        !arst_n_i |-> (!decode_i.valid && !decode_i.ctrl.regfile_we &&
                       !decode_i.ctrl.change_pc_ena && !decode_i.ex.valid && !jal_i.valid))
        else begin
            $error("control outputs active during reset");
            reset_fails = reset_fails + 1;
        end

endmodule

`default_nettype wire

// ==== tests/tb_id_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decode_macros.svh"

module tb_id_stage
    import decode_pkg::*;
();

    localparam int FIELDS  = 14;
    localparam int MAX_VEC = 64;

    logic           clk;
    logic           arst_n;
    fetch_entry_t   fetch_entry;
    decoded_instr_t decoded;
    jal_redirect_t  jal_redirect;

    // one 64-bit word per field, FIELDS words per vector
    logic [63:0] golden_mem [0:MAX_VEC*FIELDS-1];

    int num_vec       = 0;
    int vec_idx       = 0;
    int cycle_count   = 0;
    int timeout_limit = 0;
    int assert_fails  = 0;

    id_stage UUT (
        .clk_i    (clk),
        .arst_n_i (arst_n),
        .fetch_i  (fetch_entry),
        .decode_o (decoded),
        .jal_o    (jal_redirect)
    );

    bind id_stage id_stage_asserts asserts_inst (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .decode_i (decode_o),
        .jal_i    (jal_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string field, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error at %0t: vector %0d %s is %0h, expected %0h",
                                $time, vec_idx, field, got, exp));
        end
    endtask

    task automatic drive_vector(input int idx);
        int base;
        base = idx * FIELDS;
        fetch_entry.valid = golden_mem[base][0];
        fetch_entry.pc    = golden_mem[base + 2][`XLEN-1:0];
        fetch_entry.inst  = golden_mem[base + 3][`ILEN-1:0];
        // prediction bit alternates per vector
        fetch_entry.bpred = idx[0];
        // upstream fault reported against the fetch pc
        if (golden_mem[base + 1][0]) begin
            fetch_entry.ex.valid  = 1'b1;
            fetch_entry.ex.cause  = XCPT_INSTR_ADDR_MISALIGNED;
            fetch_entry.ex.origin = golden_mem[base + 2][`XLEN-1:0];
        end else begin
            fetch_entry.ex.valid  = 1'b0;
            fetch_entry.ex.cause  = XCPT_NONE;
            fetch_entry.ex.origin = '0;
        end
    endtask

    task automatic check_vector(input int idx);
        int               base;
        logic [`ILEN-1:0] inst;
        logic [6:0]       opcode;
        base    = idx * FIELDS;
        inst    = golden_mem[base + 3][`ILEN-1:0];
        opcode  = inst[6:0];
        vec_idx = idx;
        check_value("valid", decoded.valid, golden_mem[base + 4]);
        check_value("pc", decoded.pc, golden_mem[base + 2]);
        check_value("bpred", decoded.bpred, idx[0]);
        check_value("instr_type", decoded.ctrl.instr_type, golden_mem[base + 5]);
        check_value("regfile_we", decoded.ctrl.regfile_we, golden_mem[base + 6]);
        check_value("change_pc_ena", decoded.ctrl.change_pc_ena, golden_mem[base + 7]);
        check_value("mem_op", decoded.ctrl.mem_op, golden_mem[base + 8]);
        // cause f means no exception
        check_value("ex.valid", decoded.ex.valid, golden_mem[base + 9] != 64'hf);
        check_value("ex.cause", decoded.ex.cause, golden_mem[base + 9]);
        check_value("ex.origin", decoded.ex.origin, golden_mem[base + 10]);
        check_value("imm", decoded.imm, golden_mem[base + 11]);
        check_value("rd", decoded.rd, inst[11:7]);
        check_value("rs2", decoded.rs2, inst[24:20]);
        check_value("funct3", decoded.funct3, inst[14:12]);
        // lui reads x0 in place of rs1
        if (golden_mem[base][0] && !golden_mem[base + 1][0] && opcode == OP_LUI) begin
            check_value("rs1", decoded.rs1, 5'd0);
        end else begin
            check_value("rs1", decoded.rs1, inst[19:15]);
        end
        // operand select of the integer groups
        if (golden_mem[base + 4] == 64'd1 && golden_mem[base + 9] == 64'hf
                && (opcode == OP_ALU || opcode == OP_ALU_I
                    || opcode == OP_ALU_W || opcode == OP_ALU_I_W)) begin
            check_value("use_imm", decoded.ctrl.use_imm,
                        opcode == OP_ALU_I || opcode == OP_ALU_I_W);
            check_value("op_32", decoded.ctrl.op_32,
                        opcode == OP_ALU_W || opcode == OP_ALU_I_W);
        end
        check_value("jal.valid", jal_redirect.valid, golden_mem[base + 12]);
        if (golden_mem[base + 12] == 64'd1) begin
            check_value("jal.jump_addr", jal_redirect.jump_addr, golden_mem[base + 13]);
        end
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > timeout_limit) begin
            abort_run($sformatf("timeout: run did not finish within %0d cycles",
                                timeout_limit));
        end
    end

    initial begin
        arst_n      = 1'b0;
        fetch_entry = '0;
        // unfilled words hold the inverse of their address
        for (int k = 0; k < MAX_VEC * FIELDS; k++) begin
            golden_mem[k] = ~64'(k);
        end
        $readmemh("tests/id_stage_golden.txt", golden_mem);
        while (num_vec < MAX_VEC
               && golden_mem[num_vec * FIELDS] != ~64'(num_vec * FIELDS)) begin
            num_vec++;
        end
        timeout_limit = num_vec + 10;
        if (num_vec == 0) begin
            abort_run("no vectors were read from the golden file");
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        for (int i = 0; i < num_vec; i++) begin
            @(negedge clk);
            if (i > 0) begin
                check_vector(i - 1);
            end
            drive_vector(i);
        end
        @(negedge clk);
        check_vector(num_vec - 1);

        assert_fails = UUT.asserts_inst.jal_align_fails + UUT.asserts_inst.ex_we_fails
                     + UUT.asserts_inst.reset_fails;
        if (assert_fails == 0) begin
            $display("test passed");
            $finish;
        end else begin
            abort_run($sformatf("%0d assertion failures were reported", assert_fails));
        end
    end

endmodule

`default_nettype wire

// ==== tests/id_stage_golden.txt ====
// in_valid in_ex_valid pc instr | exp_valid instr_type regfile_we change_pc_ena mem_op
// cause origin imm jal_valid jal_addr (all hex, cause f is none)
1 0 80000000 003100b3 1 00 1 0 0 f 0 0 0 0
1 0 80000004 403100b3 1 01 1 0 0 f 0 0 0 0
1 0 80000008 403150b3 1 07 1 0 0 f 0 0 0 0
1 0 8000000c 003170b3 1 09 1 0 0 f 0 0 0 0
1 0 80000010 fff10093 1 00 1 0 0 f 0 ffffffffffffffff 0 0
1 0 80000014 00513093 1 04 1 0 0 f 0 5 0 0
1 0 80000018 42115093 1 07 1 0 0 f 0 421 0 0
1 0 8000001c 03f11093 1 02 1 0 0 f 0 3f 0 0
1 0 80000020 003100bb 1 0a 1 0 0 f 0 0 0 0
1 0 80000024 403150bb 1 0e 1 0 0 f 0 0 0 0
1 0 80000028 ff81009b 1 0a 1 0 0 f 0 fffffffffffffff8 0 0
1 0 8000002c 0031509b 1 0d 1 0 0 f 0 3 0 0
1 0 80000030 800000b7 1 08 1 0 0 f 0 ffffffff80000000 0 0
1 0 80000034 12345097 1 00 1 0 0 f 0 12345000 0 0
1 0 80000038 01013083 1 1a 1 0 1 f 0 10 0 0
1 0 8000003c fff14083 1 1b 1 0 1 f 0 ffffffffffffffff 0 0
1 0 80000040 00816083 1 1d 1 0 1 f 0 8 0 0
1 0 80000044 00211083 1 18 1 0 1 f 0 2 0 0
1 0 80000048 fe313c23 1 21 0 0 2 f 0 fffffffffffffff8 0 0
1 0 8000004c 7e310fa3 1 1e 0 0 2 f 0 7ff 0 0
1 0 80000050 00312223 1 20 0 0 2 f 0 4 0 0
1 0 80000054 00310863 1 11 0 1 0 f 0 10 0 0
1 0 80000058 80317063 1 16 0 1 0 f 0 fffffffffffff000 0 0
1 0 8000005c fe314fe3 1 13 0 1 0 f 0 fffffffffffffffe 0 0
1 0 80000060 004100e7 1 10 1 1 0 f 0 4 0 0
1 0 80000064 001000ef 1 0f 1 0 0 f 0 800 1 80000864
1 0 80000068 ffdff0ef 1 0f 1 0 0 f 0 fffffffffffffffc 1 80000064
1 0 8000006c 006000ef 1 0f 0 0 0 0 80000072 6 0 0
1 0 80000070 023100b3 1 00 0 0 0 2 0 0 0 0
1 0 80000074 003120af 1 00 0 0 0 2 0 0 0 0
1 0 80000078 00000073 1 00 0 0 0 2 0 0 0 0
1 0 8000007c 300110f3 1 00 0 0 0 2 0 0 0 0
1 0 80000080 00312863 1 00 0 0 0 2 0 10 0 0
1 0 80000084 80115093 1 00 0 0 0 2 0 fffffffffffff801 0 0
1 0 80000088 0051209b 1 00 0 0 0 2 0 5 0 0
1 1 8000008c 003100b3 1 00 0 0 0 0 8000008c 0 0 0
1 1 80000090 001000ef 1 00 0 0 0 0 80000090 800 0 0
0 0 80000094 001000ef 0 00 0 0 0 f 0 800 0 0
0 0 80000098 01013083 0 00 0 0 0 f 0 10 0 0

// ==== tb.f ====
+incdir+hdl
hdl/decode_pkg.sv
hdl/imm_gen.sv
hdl/int_op_decode.sv
hdl/flow_mem_decode.sv
hdl/id_stage.sv
tests/id_stage_asserts.sv
tests/tb_id_stage.sv

// ==== Makefile ====
# Verilator flow for the decode stage
VERILATOR ?= verilator
TOP       ?= tb_id_stage
RTL_TOP   ?= id_stage
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= test passed
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
